/* source/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Byte address width of the CPU and of the shared bus.
`define FETCH_ADDR_WIDTH 32

// Number of index bits of the direct-mapped instruction cache.
// Six bits give 64 entries of one word each.
`define ICACHE_INDEX_BITS 6

// The tag holds the address bits above the index and the byte offset.
`define ICACHE_TAG_BITS (`FETCH_ADDR_WIDTH - `ICACHE_INDEX_BITS - 2)

// Main memory depth in words, as a power of two.
`define MEM_WORDS_LOG2 10

// Cycles the memory waits before it raises ack.
`define MEM_WAIT_STATES 2

// Width of a data word on every path.
`define WORD_WIDTH 32

// Number of byte lanes in a word.
`define WORD_BYTES 4

`endif

/* source/fetch_pkg.sv */
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

	// Wishbone classic signals from master to slave.
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`WORD_BYTES-1:0] sel;
		logic [`FETCH_ADDR_WIDTH-1:0] adr;
		logic [`WORD_WIDTH-1:0] dat;
	} wb_m2s_t;

	// Wishbone classic signals from slave to master.
	typedef struct packed {
		logic ack;
		logic [`WORD_WIDTH-1:0] dat;
	} wb_s2m_t;

	// Instruction fetch request and response.
	typedef struct packed {
		logic valid;
		logic [`FETCH_ADDR_WIDTH-1:0] pc;
	} fetch_req_t;

	typedef struct packed {
		logic ready;
		logic [`WORD_WIDTH-1:0] instr;
	} fetch_rsp_t;

	// Load/store request and response.
	typedef struct packed {
		logic valid;
		logic write;
		logic [`FETCH_ADDR_WIDTH-1:0] addr;
		logic [`WORD_WIDTH-1:0] wdata;
	} data_req_t;

	typedef struct packed {
		logic done;
		logic [`WORD_WIDTH-1:0] rdata;
	} data_rsp_t;

	typedef enum logic [1:0] {INITIALIZE, IDLE, LOOKUP, FILL} icache_state_t;

	// Data port FSM states.
	typedef enum logic {DP_IDLE, DP_BUS} data_state_t;

	typedef enum logic [1:0] {NONE, FETCH, DATA} arb_owner_t;

	// One cache line of a single word.
	typedef struct packed {
		logic valid;
		logic [`ICACHE_TAG_BITS-1:0] tag;
		logic [`WORD_WIDTH-1:0] word;
	} icache_entry_t;

endpackage

`default_nettype wire

/* source/cache_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module cache_ram
	import fetch_pkg::*;
(
	input  wire                           i_clock,
	input  wire                           i_write,
	input  wire [`ICACHE_INDEX_BITS-1:0]  i_index,
	input  wire icache_entry_t            i_wdata,
	output icache_entry_t                 o_rdata
);

	localparam int ENTRIES = 1 << `ICACHE_INDEX_BITS;

	icache_entry_t mem [0:ENTRIES-1];

	// Read data follows the index by one cycle.
	// A read of the entry being written returns its old contents.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_index] <= i_wdata;
		end
		o_rdata <= mem[i_index];
	end

endmodule

`default_nettype wire

/* source/icache.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module icache
	import fetch_pkg::*;
(
	input  wire             i_clock,
	input  wire             i_reset,
	input  wire fetch_req_t i_fetch,
	input  wire             i_stall,
	output fetch_rsp_t      o_fetch,
	output wb_m2s_t         o_wb,
	input  wire wb_s2m_t    i_wb
);

	localparam int IDX_LO = 2;
	localparam int IDX_HI = `ICACHE_INDEX_BITS + 1;
	localparam int TAG_LO = `ICACHE_INDEX_BITS + 2;

	icache_state_t state_q;
	logic [`ICACHE_INDEX_BITS-1:0] clear_q;
	logic [`FETCH_ADDR_WIDTH-1:0] pc_q;
	logic ready_q;
	logic [`WORD_WIDTH-1:0] instr_q;
	logic cyc_q;

	logic ram_write;
	logic [`ICACHE_INDEX_BITS-1:0] ram_index;
	icache_entry_t ram_wdata;
	icache_entry_t ram_rdata;
	logic hit;

	cache_ram u_cache_ram (
		.i_clock (i_clock),
		.i_write (ram_write),
		.i_index (ram_index),
		.i_wdata (ram_wdata),
		.o_rdata (ram_rdata)
	);

	// Stored line matches the latched pc.
	assign hit = ram_rdata.valid && (ram_rdata.tag == pc_q[`FETCH_ADDR_WIDTH-1:TAG_LO]);

	// RAM port selection.
	// In IDLE the incoming pc addresses the RAM so the entry is ready in LOOKUP.
	always_comb begin
		ram_write = 1'b0;
		ram_index = pc_q[IDX_HI:IDX_LO];
		ram_wdata = '0;
		case (state_q)
			INITIALIZE: begin
				ram_write = 1'b1;
				ram_index = clear_q;
			end
			IDLE: begin
				ram_index = i_fetch.pc[IDX_HI:IDX_LO];
			end
			FILL: begin
				ram_write = i_wb.ack;
				ram_wdata.valid = 1'b1;
				ram_wdata.tag = pc_q[`FETCH_ADDR_WIDTH-1:TAG_LO];
				ram_wdata.word = i_wb.dat;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state_q <= INITIALIZE;
			clear_q <= '0;
			ready_q <= 1'b0;
			cyc_q <= 1'b0;
		end else begin
			ready_q <= 1'b0;
			case (state_q)
				INITIALIZE: begin
					// One invalid entry per cycle.
					clear_q <= clear_q + 1'b1;
					if (&clear_q) begin
						state_q <= IDLE;
					end
				end
				IDLE: begin
					// The CPU still holds the old request in the cycle of ready.
					if (i_fetch.valid && !i_stall && !ready_q) begin
						state_q <= LOOKUP;
					end
				end
				LOOKUP: begin
					if (i_stall) begin
						state_q <= IDLE;
					end else if (hit) begin
						ready_q <= 1'b1;
						state_q <= IDLE;
					end else begin
						cyc_q <= 1'b1;
						state_q <= FILL;
					end
				end
				FILL: begin
					// The line is written on ack.
					// Under stall the word is not returned and the retry hits.
					if (i_wb.ack) begin
						cyc_q <= 1'b0;
						ready_q <= !i_stall;
						state_q <= IDLE;
					end
				end
				default: begin
					state_q <= INITIALIZE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state_q == IDLE) begin
			pc_q <= i_fetch.pc;
		end
		if (state_q == LOOKUP && hit) begin
			instr_q <= ram_rdata.word;
		end else if (state_q == FILL && i_wb.ack) begin
			instr_q <= i_wb.dat;
		end
	end

	always_comb begin
		o_fetch.ready = ready_q;
		o_fetch.instr = instr_q;
	end

	// Single word read of the missing pc.
	always_comb begin
		o_wb.cyc = cyc_q;
		o_wb.stb = cyc_q;
		o_wb.we = 1'b0;
		o_wb.sel = '1;
		o_wb.adr = {pc_q[`FETCH_ADDR_WIDTH-1:2], 2'b00};
		o_wb.dat = '0;
	end

endmodule

`default_nettype wire

/* source/data_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module data_port
	import fetch_pkg::*;
(
	input  wire            i_clock,
	input  wire            i_reset,
	input  wire data_req_t i_data,
	output data_rsp_t      o_data,
	output wb_m2s_t        o_wb,
	input  wire wb_s2m_t   i_wb
);

	data_state_t state_q;
	logic cyc_q;
	logic done_q;
	logic we_q;
	logic [`FETCH_ADDR_WIDTH-1:0] addr_q;
	logic [`WORD_WIDTH-1:0] wdata_q;
	logic [`WORD_WIDTH-1:0] rdata_q;
	logic accept;

	// A new request is not taken while done is still visible to the CPU.
	assign accept = (state_q == DP_IDLE) && i_data.valid && !done_q;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state_q <= DP_IDLE;
			cyc_q <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				DP_IDLE: begin
					if (accept) begin
						cyc_q <= 1'b1;
						state_q <= DP_BUS;
					end
				end
				DP_BUS: begin
					if (i_wb.ack) begin
						cyc_q <= 1'b0;
						done_q <= 1'b1;
						state_q <= DP_IDLE;
					end
				end
				default: begin
					state_q <= DP_IDLE;
				end
			endcase
		end
	end

	// Request payload and read data.
	always_ff @(posedge i_clock) begin
		if (accept) begin
			we_q <= i_data.write;
			addr_q <= {i_data.addr[`FETCH_ADDR_WIDTH-1:2], 2'b00};
			wdata_q <= i_data.wdata;
		end
		if (state_q == DP_BUS && i_wb.ack) begin
			rdata_q <= we_q ? '0 : i_wb.dat;
		end
	end

	always_comb begin
		o_data.done = done_q;
		o_data.rdata = rdata_q;
		o_wb.cyc = cyc_q;
		o_wb.stb = cyc_q;
		o_wb.we = we_q;
		o_wb.sel = '1;
		o_wb.adr = addr_q;
		o_wb.dat = wdata_q;
	end

endmodule

`default_nettype wire

/* source/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter
	import fetch_pkg::*;
(
	input  wire          i_clock,
	input  wire          i_reset,
	input  wire wb_m2s_t i_fetch_wb,
	output wb_s2m_t      o_fetch_wb,
	input  wire wb_m2s_t i_data_wb,
	output wb_s2m_t      o_data_wb,
	output wb_m2s_t      o_mem_wb,
	input  wire wb_s2m_t i_mem_wb
);

	arb_owner_t owner_q;
	arb_owner_t last_q;
	logic fetch_first;

	// On a tie the master not served last wins.
	assign fetch_first = i_fetch_wb.cyc && (!i_data_wb.cyc || last_q != FETCH);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			owner_q <= NONE;
			last_q <= NONE;
		end else begin
			case (owner_q)
				NONE: begin
					if (fetch_first) begin
						owner_q <= FETCH;
						last_q <= FETCH;
					end else if (i_data_wb.cyc) begin
						owner_q <= DATA;
						last_q <= DATA;
					end
				end
				FETCH: begin
					if (!i_fetch_wb.cyc) begin
						owner_q <= NONE;
					end
				end
				DATA: begin
					if (!i_data_wb.cyc) begin
						owner_q <= NONE;
					end
				end
				default: begin
					owner_q <= NONE;
				end
			endcase
		end
	end

	// Only the owner reaches the memory.
	always_comb begin
		case (owner_q)
			FETCH: o_mem_wb = i_fetch_wb;
			DATA: o_mem_wb = i_data_wb;
			default: o_mem_wb = '0;
		endcase
	end

	// Ack and data go back to the owner only.
	always_comb begin
		o_fetch_wb.ack = (owner_q == FETCH) && i_mem_wb.ack;
		o_fetch_wb.dat = (owner_q == FETCH) ? i_mem_wb.dat : '0;
		o_data_wb.ack = (owner_q == DATA) && i_mem_wb.ack;
		o_data_wb.dat = (owner_q == DATA) ? i_mem_wb.dat : '0;
	end

endmodule

`default_nettype wire

/* source/main_memory.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module main_memory
	import fetch_pkg::*;
(
	input  wire          i_clock,
	input  wire          i_reset,
	input  wire wb_m2s_t i_wb,
	output wb_s2m_t      o_wb
);

	localparam int WORDS = 1 << `MEM_WORDS_LOG2;
	localparam int WAIT_WIDTH = $clog2(`MEM_WAIT_STATES + 2);

	logic [`WORD_WIDTH-1:0] mem [0:WORDS-1];
	logic [WAIT_WIDTH-1:0] wait_q;
	logic ack_q;
	logic served_q;
	logic [`WORD_WIDTH-1:0] rdata_q;
	logic active;
	logic ack_rise;
	logic [`MEM_WORDS_LOG2-1:0] index;

	assign active = i_wb.cyc && i_wb.stb;
	assign ack_rise = active && !served_q && (wait_q == WAIT_WIDTH'(`MEM_WAIT_STATES));
	assign index = i_wb.adr[`MEM_WORDS_LOG2+1:2];

	// The wait counter allows one ack per strobe.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_q <= '0;
			ack_q <= 1'b0;
			served_q <= 1'b0;
		end else begin
			ack_q <= ack_rise;
			if (!active) begin
				wait_q <= '0;
				served_q <= 1'b0;
			end else if (ack_rise) begin
				wait_q <= '0;
				served_q <= 1'b1;
			end else if (!served_q) begin
				wait_q <= wait_q + 1'b1;
			end
		end
	end

	// Access happens on the edge that raises ack.
	always_ff @(posedge i_clock) begin
		if (ack_rise) begin
			if (i_wb.we) begin
				for (int b = 0; b < `WORD_BYTES; b++) begin
					if (i_wb.sel[b]) begin
						mem[index][8*b +: 8] <= i_wb.dat[8*b +: 8];
					end
				end
			end
			rdata_q <= mem[index];
		end
	end

	always_comb begin
		o_wb.ack = ack_q;
		o_wb.dat = rdata_q;
	end

endmodule

`default_nettype wire

/* source/fetch_memory_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_memory_top
	import fetch_pkg::*;
(
	input  wire             i_clock,
	input  wire             i_reset,
	input  wire fetch_req_t i_fetch,
	input  wire             i_stall,
	output fetch_rsp_t      o_fetch,
	input  wire data_req_t  i_data,
	output data_rsp_t       o_data
);

	wb_m2s_t fetch_m2s;
	wb_s2m_t fetch_s2m;
	wb_m2s_t data_m2s;
	wb_s2m_t data_s2m;
	wb_m2s_t mem_m2s;
	wb_s2m_t mem_s2m;

	icache u_icache (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_fetch (i_fetch),
		.i_stall (i_stall),
		.o_fetch (o_fetch),
		.o_wb    (fetch_m2s),
		.i_wb    (fetch_s2m)
	);

	data_port u_data_port (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_data  (i_data),
		.o_data  (o_data),
		.o_wb    (data_m2s),
		.i_wb    (data_s2m)
	);

	// Both masters share the one memory slave.
	bus_arbiter u_bus_arbiter (
		.i_clock    (i_clock),
		.i_reset    (i_reset),
		.i_fetch_wb (fetch_m2s),
		.o_fetch_wb (fetch_s2m),
		.i_data_wb  (data_m2s),
		.o_data_wb  (data_s2m),
		.o_mem_wb   (mem_m2s),
		.i_mem_wb   (mem_s2m)
	);

	main_memory u_main_memory (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_wb    (mem_m2s),
		.o_wb    (mem_s2m)
	);

endmodule

`default_nettype wire

/* dv/tb_fetch_memory.sv */
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module tb_fetch_memory
	import fetch_pkg::*;
();

	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 5;
	localparam int INIT_CYCLES = 1 << `ICACHE_INDEX_BITS;
	localparam int MAX_WAIT = 100;
	localparam int STALL_CYCLES = 8;
	localparam int NUM_ROWS = 74;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * 200 + INIT_CYCLES + RESET_CYCLES;
	localparam logic [31:0] INIT_ADDR = 32'h3c0;

	typedef enum logic [2:0] {OP_STORE, OP_LOAD, OP_FETCH, OP_HIT, OP_STALL_FETCH, OP_DUAL} op_t;

	// Only the combined load and fetch uses addr_b.
	typedef struct packed {
		op_t op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] expected;
		logic [31:0] addr_b;
		logic [31:0] expected_b;
	} row_t;

	logic i_clock = 1'b0;
	logic i_reset;
	fetch_req_t i_fetch;
	logic i_stall;
	fetch_rsp_t o_fetch;
	data_req_t i_data;
	data_rsp_t o_data;

	row_t rows [0:NUM_ROWS-1];
	int row_count;
	logic [`WORD_WIDTH-1:0] ref_mem [0:(1 << `MEM_WORDS_LOG2)-1];
	integer seed;
	int test_count;
	int error_count;

	fetch_memory_top i_fetch_memory_top (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_fetch (i_fetch),
		.i_stall (i_stall),
		.o_fetch (o_fetch),
		.i_data  (i_data),
		.o_data  (o_data)
	);

	always #(CLOCK_PERIOD / 2) i_clock = ~i_clock;

	function automatic logic [`MEM_WORDS_LOG2-1:0] word_index(input logic [31:0] addr);
		return addr[`MEM_WORDS_LOG2+1:2];
	endfunction

	// Stores update the reference memory and later rows take their expected words from it.
	task automatic add_row(input op_t op, input logic [31:0] addr, input logic [31:0] addr_b);
		row_t row;
		row = '0;
		row.op = op;
		row.addr = addr;
		row.addr_b = addr_b;
		if (op == OP_STORE) begin
			row.wdata = $random(seed);
			ref_mem[word_index(addr)] = row.wdata;
		end
		row.expected = ref_mem[word_index(addr)];
		row.expected_b = ref_mem[word_index(addr_b)];
		if (row_count < NUM_ROWS) begin
			rows[row_count] = row;
		end
		row_count++;
	endtask

	task automatic build_table();
		row_count = 0;
		for (int k = 0; k < 16; k++) begin
			add_row(OP_STORE, 32'h200 + 4 * k, 32'h0);
		end
		// These two share one cache index and differ in tag.
		add_row(OP_STORE, 32'h040, 32'h0);
		add_row(OP_STORE, 32'h140, 32'h0);
		// Words for the combined and the stalled rows.
		add_row(OP_STORE, 32'h380, 32'h0);
		add_row(OP_STORE, 32'h384, 32'h0);
		for (int k = 0; k < 16; k++) begin
			add_row(OP_LOAD, 32'h200 + 4 * k, 32'h0);
		end
		for (int k = 0; k < 16; k++) begin
			add_row(OP_FETCH, 32'h200 + 4 * k, 32'h0);
		end
		for (int k = 0; k < 16; k++) begin
			add_row(OP_HIT, 32'h200 + 4 * k, 32'h0);
		end
		// The hit shows that the second tag replaced the first one.
		add_row(OP_FETCH, 32'h040, 32'h0);
		add_row(OP_FETCH, 32'h140, 32'h0);
		add_row(OP_HIT, 32'h140, 32'h0);
		add_row(OP_FETCH, 32'h040, 32'h0);
		// Load and cache miss compete for the bus.
		add_row(OP_DUAL, 32'h20c, 32'h380);
		add_row(OP_STALL_FETCH, 32'h384, 32'h0);
	endtask

	task automatic step_cycle();
		@(posedge i_clock);
		#2;
	endtask

	task automatic fail_test(input int row, input string what);
		error_count++;
		$display("test %0d failed: %s", row, what);
	endtask

	task automatic check_instr(input int row, input fetch_rsp_t got, input logic [31:0] expected);
		if (got.instr !== expected) begin
			error_count++;
			$display("error at %0t ns: o_fetch.instr got %h expected %h (test %0d)",
				$time, got.instr, expected, row);
		end else begin
			$display("test %0d fetch ok: %h", row, got.instr);
		end
	endtask

	task automatic check_load(input int row, input data_rsp_t got, input logic [31:0] expected);
		if (got.rdata !== expected) begin
			error_count++;
			$display("error at %0t ns: o_data.rdata got %h expected %h (test %0d)",
				$time, got.rdata, expected, row);
		end else begin
			$display("test %0d load ok: %h", row, got.rdata);
		end
	endtask

	task automatic run_fetch(input int row, input logic [31:0] addr, input logic [31:0] expected,
			input bit check_latency);
		int cycles;
		cycles = 0;
		i_fetch.valid = 1'b1;
		i_fetch.pc = addr;
		do begin
			step_cycle();
			cycles++;
		end while (!o_fetch.ready && cycles < MAX_WAIT);
		i_fetch.valid = 1'b0;
		if (!o_fetch.ready) begin
			fail_test(row, "no instruction from the cache before the timeout");
		end else if (check_latency && cycles != 2) begin
			fail_test(row, $sformatf("hit answered after %0d cycles instead of 2", cycles));
		end else begin
			check_instr(row, o_fetch, expected);
		end
	endtask

	task automatic run_data(input int row, input logic write, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [31:0] expected);
		int cycles;
		cycles = 0;
		i_data.valid = 1'b1;
		i_data.write = write;
		i_data.addr = addr;
		i_data.wdata = wdata;
		do begin
			step_cycle();
			cycles++;
		end while (!o_data.done && cycles < MAX_WAIT);
		i_data.valid = 1'b0;
		if (!o_data.done) begin
			fail_test(row, "no done from the data port before the timeout");
		end else if (write) begin
			$display("test %0d store ok: [%h] = %h", row, addr, wdata);
		end else begin
			check_load(row, o_data, expected);
		end
	endtask

	task automatic run_dual(input int row, input logic [31:0] load_addr,
			input logic [31:0] load_expected, input logic [31:0] fetch_addr,
			input logic [31:0] fetch_expected);
		fetch_rsp_t fetch_got;
		data_rsp_t load_got;
		int cycles;
		fetch_got = '0;
		load_got = '0;
		cycles = 0;
		i_data.valid = 1'b1;
		i_data.write = 1'b0;
		i_data.addr = load_addr;
		i_fetch.valid = 1'b1;
		i_fetch.pc = fetch_addr;
		// Each request is dropped as soon as its own pulse is seen.
		while ((!fetch_got.ready || !load_got.done) && cycles < MAX_WAIT) begin
			step_cycle();
			cycles++;
			if (o_fetch.ready) begin
				fetch_got = o_fetch;
				i_fetch.valid = 1'b0;
			end
			if (o_data.done) begin
				load_got = o_data;
				i_data.valid = 1'b0;
			end
		end
		i_fetch.valid = 1'b0;
		i_data.valid = 1'b0;
		if (!fetch_got.ready || !load_got.done) begin
			fail_test(row, "load and fetch did not both finish before the timeout");
		end else begin
			check_load(row, load_got, load_expected);
			check_instr(row, fetch_got, fetch_expected);
		end
	endtask

	// Stall rises once the cache has moved to LOOKUP.
	task automatic run_stalled_fetch(input int row, input logic [31:0] addr,
			input logic [31:0] expected);
		bit early;
		early = 1'b0;
		i_fetch.valid = 1'b1;
		i_fetch.pc = addr;
		step_cycle();
		i_stall = 1'b1;
		repeat (STALL_CYCLES) begin
			step_cycle();
			if (o_fetch.ready) begin
				early = 1'b1;
			end
		end
		i_stall = 1'b0;
		if (early) begin
			i_fetch.valid = 1'b0;
			fail_test(row, "cache answered while the stall was held");
		end else begin
			run_fetch(row, addr, expected, 1'b0);
		end
	endtask

	// The fetch is held from the first cycle while a store puts its word in memory.
	task automatic run_init_fetch();
		int cycles;
		bit stored;
		logic [31:0] value;
		value = $random(seed);
		ref_mem[word_index(INIT_ADDR)] = value;
		cycles = 0;
		stored = 1'b0;
		test_count++;
		i_fetch.valid = 1'b1;
		i_fetch.pc = INIT_ADDR;
		i_data.valid = 1'b1;
		i_data.write = 1'b1;
		i_data.addr = INIT_ADDR;
		i_data.wdata = value;
		do begin
			step_cycle();
			cycles++;
			if (o_data.done) begin
				stored = 1'b1;
				i_data.valid = 1'b0;
			end
		end while (!o_fetch.ready && cycles < INIT_CYCLES + MAX_WAIT);
		i_fetch.valid = 1'b0;
		i_data.valid = 1'b0;
		if (!stored) begin
			fail_test(0, "store during tag clearing never finished");
		end else if (!o_fetch.ready) begin
			fail_test(0, "no instruction after tag clearing before the timeout");
		end else if (cycles <= INIT_CYCLES) begin
			fail_test(0, $sformatf("cache answered after %0d cycles, during tag clearing", cycles));
		end else begin
			check_instr(0, o_fetch, ref_mem[word_index(INIT_ADDR)]);
		end
	endtask

	initial begin
		seed = 32'h38ba;
		test_count = 0;
		error_count = 0;
		i_reset = 1'b1;
		i_fetch = '0;
		i_stall = 1'b0;
		i_data = '0;
		build_table();
		if (row_count != NUM_ROWS) begin
			error_count++;
			$display("stimulus table holds %0d rows instead of %0d", row_count, NUM_ROWS);
		end
		repeat (RESET_CYCLES) step_cycle();
		i_reset = 1'b0;
		run_init_fetch();
		step_cycle();
		for (int r = 0; r < row_count && r < NUM_ROWS; r++) begin
			test_count++;
			case (rows[r].op)
				OP_STORE: run_data(r + 1, 1'b1, rows[r].addr, rows[r].wdata, rows[r].expected);
				OP_LOAD: run_data(r + 1, 1'b0, rows[r].addr, 32'h0, rows[r].expected);
				OP_FETCH: run_fetch(r + 1, rows[r].addr, rows[r].expected, 1'b0);
				OP_HIT: run_fetch(r + 1, rows[r].addr, rows[r].expected, 1'b1);
				OP_STALL_FETCH: run_stalled_fetch(r + 1, rows[r].addr, rows[r].expected);
				default: begin
					run_dual(r + 1, rows[r].addr, rows[r].expected, rows[r].addr_b,
						rows[r].expected_b);
				end
			endcase
			// Idle cycle so the last response pulse has ended.
			step_cycle();
		end
		$display("%0d tests run, %0d errors", test_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/fetch_pkg.sv
source/cache_ram.sv
source/icache.sv
source/data_port.sv
source/bus_arbiter.sv
source/main_memory.sv
source/fetch_memory_top.sv
dv/tb_fetch_memory.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_fetch_memory
RTL_TOP    = fetch_memory_top
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
